// ==== logic/map_pkg.sv ====
// Main CPU memory map of the two-video-chip board
// Only the regions handled by this glue are listed; work RAM stays outside
// Read-source indices give the one-hot layout of rd_sel, lowest index wins
package map_pkg;

    localparam int NUM_VID  = 2;               // Identical video chips
    localparam int VRAM_AW  = 13;              // 8 KB window at 0x2000-0x3FFF
    localparam int CFG_N    = 8;               // Config bytes per chip, write-only
    localparam int CFG_AW   = $clog2(CFG_N);   // Config index bits, 0x00-0x07

    // ROM banking
    localparam int ROM_AW      = 17;
    localparam int BANK_W      = 4;
    localparam int BANK_OFS    = 4;                 // Bank 0 starts at 0x08000 in ROM
    localparam int ROM_PAGE_AW = ROM_AW - BANK_W;   // 13 bits inside one bank
    localparam logic [1:0] BANK_WIN = 2'b01;        // A[15:14], 0x4000-0x7FFF

    // High-byte pages
    localparam logic [7:0] PAGE_IO  = 8'h04;
    localparam logic [7:0] PAGE_PAL = 8'h06;
    localparam logic [3:0] PAGE_RAM = 4'h1;         // 0x1000-0x1FFF, external work RAM
    localparam int         IO_OUT_BIT = 4;          // A[4] splits inputs from outputs

    // VRAM sits right above the work RAM page
    localparam logic [15:0] VRAM_BASE = 16'({PAGE_RAM + 4'h1, 12'h000});

    // Unmapped reads float high
    localparam logic [7:0] IDLE_DATA = 8'hFF;

    // Read sources, in priority order
    localparam int SEL_ROM = 0;
    localparam int SEL_PAL = 1;
    localparam int SEL_IN  = 2;
    localparam int SEL_VID = 3;                     // First of NUM_VID VRAM slots
    localparam int SEL_N   = SEL_VID + NUM_VID;

endpackage

// ==== logic/cab_pkg.sv ====
// Cabinet I/O layout on page 0x04
// Inputs use A[2:0] with A[4] clear, outputs use A[2:1] with A[4] set
// Offsets 3 and 7 are not wired and read as idle
package cab_pkg;

    // Input port offsets, A[2:0]
    localparam logic [2:0] PORT_SYS  = 3'd0;   // Start, service, coin
    localparam logic [2:0] PORT_JOY1 = 3'd1;
    localparam logic [2:0] PORT_JOY2 = 3'd2;
    localparam logic [2:0] PORT_DSWA = 3'd4;
    localparam logic [2:0] PORT_DSWB = 3'd5;
    localparam logic [2:0] PORT_DSWC = 3'd6;

    // Widths
    localparam int BTN_W  = 2;   // Start buttons and coin slots, one per player
    localparam int JOY_W  = 6;   // 4 directions plus 2 buttons
    localparam int DSW_W  = 8;   // DIP banks A and B
    localparam int DSWC_W = 4;   // DIP bank C, upper nibble reads as ones

    // Output offsets, A[2:1]
    // 0 is the coin counter and 3 the watchdog, neither handled here
    localparam logic [1:0] OUT_SND_IRQ   = 2'd1;
    localparam logic [1:0] OUT_SND_LATCH = 2'd2;

endpackage

// ==== logic/main_decode.sv ====
// Main bus address decoder, bank register and ROM address
// Selects are combinational from the address; bank and video_sel move on
// the cpu_cen write edge. Work RAM at 0x1000 decodes to nothing here.
// bus_wait needs rom_ok from the ROM side, it is not registered
`timescale 1ns/1ps

module main_decode import map_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cen,
    input  logic [15:0]         addr,
    input  logic                rnw,
    input  logic [7:0]          cpu_dout,
    input  logic                rom_ok,
    output logic                rom_cs,
    output logic [ROM_AW-1:0]   rom_addr,
    output logic                bus_wait,
    output logic [NUM_VID-1:0]  vram_cs,
    output logic [NUM_VID-1:0]  cfg_cs,
    output logic                pal_cs,
    output logic                in_cs,
    output logic                out_cs,
    output logic [SEL_N-1:0]    rd_sel
);

    logic [BANK_W-1:0] bank;
    logic              video_sel;   // Which chip the shared window reaches
    logic              bank_wr;
    logic              io_hit;
    logic              vram_hit;
    logic              cfg_hit;

    always_comb begin
        rom_cs   = (addr[15] || addr[15:14] == BANK_WIN) && rnw;  // 4000-FFFF reads
        bank_wr  = addr[15:14] == BANK_WIN && !rnw;               // Same window, writes
        pal_cs   = addr[15:8] == PAGE_PAL;                        // 0600-06FF
        io_hit   = addr[15:8] == PAGE_IO;                         // 0400-04FF
        in_cs    = io_hit && !addr[IO_OUT_BIT] &&  rnw;
        out_cs   = io_hit &&  addr[IO_OUT_BIT] && !rnw;
        vram_hit = addr[15:VRAM_AW] == VRAM_BASE[15:VRAM_AW];     // 2000-3FFF
        cfg_hit  = addr[15:CFG_AW] == '0;                         // 0000-0007
        for (int i = 0; i < NUM_VID; i++) begin
            vram_cs[i] = vram_hit && video_sel == 1'(i);
            cfg_cs[i]  = cfg_hit && !rnw && video_sel == 1'(i);   // Write-only regs
        end
    end

    // Read source, one-hot, same order as the mux priority
    always_comb begin
        rd_sel          = '0;
        rd_sel[SEL_ROM] = rom_cs;
        rd_sel[SEL_PAL] = pal_cs;
        rd_sel[SEL_IN]  = in_cs;
        for (int i = 0; i < NUM_VID; i++)
            rd_sel[SEL_VID+i] = vram_cs[i];
    end

    // Upper half is fixed, lower window goes through the bank
    always_comb begin
        if (addr[15])
            rom_addr = ROM_AW'(addr[14:0]);
        else
            rom_addr = {bank + BANK_W'(BANK_OFS), addr[ROM_PAGE_AW-1:0]};
    end

    assign bus_wait = rom_cs && !rom_ok;   // Hold the CPU until the ROM answers

    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= '0;
            video_sel <= 1'b0;
        end else if (cpu_cen && bank_wr) begin
            bank      <= cpu_dout[BANK_W-1:0];
            video_sel <= cpu_dout[BANK_W];   // Bit 4, just above the bank
        end
    end

endmodule

// ==== logic/vid_port.sv ====
// CPU side of one video chip: 8 KB VRAM and the config bytes
// VRAM read is synchronous, one clk, and runs every cycle
// Config bytes cannot be read back; the renderer sees them flat,
// byte n at bits 8n+7:8n
`timescale 1ns/1ps

module vid_port import map_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_cen,
    input  logic                  rnw,
    input  logic [VRAM_AW-1:0]    addr,
    input  logic [7:0]            cpu_dout,
    input  logic                  vram_cs,
    input  logic                  cfg_cs,
    output logic [7:0]            vid_dout,
    output logic [CFG_N*8-1:0]    cfg_regs
);

    logic [7:0] vram [2**VRAM_AW];
    logic [7:0] cfg  [CFG_N];
    logic       vram_we;

    assign vram_we = cpu_cen && vram_cs && !rnw;   // One write per bus cycle

    // Write port
    always_ff @(posedge clk) begin
        if (vram_we)
            vram[addr] <= cpu_dout;
    end

    // Read port, valid one edge after the address
    always_ff @(posedge clk) begin
        vid_dout <= vram[addr];
    end

    // Config registers clear on reset so the renderer starts blank
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CFG_N; i++)
                cfg[i] <= 8'h00;
        end else if (cpu_cen && cfg_cs) begin
            cfg[addr[CFG_AW-1:0]] <= cpu_dout;   // Low bits pick the register
        end
    end

    // Flatten for the renderer
    always_comb begin
        for (int i = 0; i < CFG_N; i++)
            cfg_regs[i*8 +: 8] = cfg[i];
    end

endmodule

// ==== logic/cab_inputs.sv ====
// Cabinet input ports, registered every clk from A[2:0]
// Inputs are active low as they come from the harness
// Joystick bits are reordered to match the board wiring
// Outside an input read, or at offsets 3 and 7, the port reads 0xFF
`timescale 1ns/1ps

module cab_inputs import cab_pkg::*; (
    input  logic              clk,
    input  logic              in_cs,
    input  logic [2:0]        addr_lo,
    input  logic [BTN_W-1:0]  start_button,
    input  logic [BTN_W-1:0]  coin_input,
    input  logic [JOY_W-1:0]  joystick1,
    input  logic [JOY_W-1:0]  joystick2,
    input  logic              service,
    input  logic [DSW_W-1:0]  dipsw_a,
    input  logic [DSW_W-1:0]  dipsw_b,
    input  logic [DSWC_W-1:0] dipsw_c,
    output logic [7:0]        port_in
);

    // Buttons kept, then up/down and left/right swapped pairwise
    function automatic logic [7:0] joy_port(input logic [JOY_W-1:0] joy);
        return {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    always_ff @(posedge clk) begin
        if (!in_cs) begin
            port_in <= 8'hFF;   // Keeps the register quiet on other traffic
        end else begin
            case (addr_lo)
                PORT_SYS:  port_in <= {3'b111, start_button, service, coin_input};
                PORT_JOY1: port_in <= joy_port(joystick1);
                PORT_JOY2: port_in <= joy_port(joystick2);
                PORT_DSWA: port_in <= dipsw_a;
                PORT_DSWB: port_in <= dipsw_b;
                PORT_DSWC: port_in <= {{(8-DSWC_W){1'b1}}, dipsw_c};   // Pad with ones
                default:   port_in <= 8'hFF;
            endcase
        end
    end

endmodule

// ==== logic/snd_comm.sv ====
// Sound CPU latch and interrupt, plus the video interrupt flip-flop
// snd_irq is high for one cpu_cen period per write
// irq_n falls one edge after a gfx_irqn fall when dip_pause is high;
// a fall on the same edge as irq_ack wins over the acknowledge
`timescale 1ns/1ps

module snd_comm import cab_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cen,
    input  logic        out_cs,
    input  logic [2:1]  addr,
    input  logic [7:0]  cpu_dout,
    input  logic        gfx_irqn,
    input  logic        dip_pause,
    input  logic        irq_ack,
    output logic        snd_irq,
    output logic [7:0]  snd_latch,
    output logic        irq_n
);

    logic gfx_irqn_l;   // Last sampled gfx_irqn
    logic gfx_fall;

    always_ff @(posedge clk) begin
        if (rst) begin
            snd_irq   <= 1'b0;
            snd_latch <= 8'h00;
        end else if (cpu_cen) begin
            snd_irq <= 1'b0;   // Drops at the next bus cycle
            if (out_cs) begin
                case (addr)
                    OUT_SND_IRQ:   snd_irq   <= 1'b1;
                    OUT_SND_LATCH: snd_latch <= cpu_dout;
                    default: ;   // Coin counters and watchdog live elsewhere
                endcase
            end
        end
    end

    assign gfx_fall = gfx_irqn_l && !gfx_irqn;

    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_irqn_l <= 1'b1;   // No false edge out of reset
            irq_n      <= 1'b1;
        end else begin
            gfx_irqn_l <= gfx_irqn;
            if (gfx_fall && dip_pause)
                irq_n <= 1'b0;    // dip_pause high means running
            else if (irq_ack)
                irq_n <= 1'b1;
        end
    end

endmodule

// ==== logic/bus_mux.sv ====
// Read data back to the CPU, priority select then one register
// Priority: ROM, palette, input port, VRAM 0, VRAM 1; else 0xFF
// rd_sel is combinational from the address, so the CPU must hold the
// address until it samples cpu_din
`timescale 1ns/1ps

module bus_mux import map_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [SEL_N-1:0]  rd_sel,
    input  logic [7:0]        rom_data,
    input  logic [7:0]        pal_dout,
    input  logic [7:0]        port_in,
    input  logic [7:0]        vid_dout [NUM_VID],
    output logic [7:0]        cpu_din
);

    logic [7:0] mux_d;

    // Later assignments win, so the lowest source index has priority
    always_comb begin
        mux_d = IDLE_DATA;
        for (int i = NUM_VID - 1; i >= 0; i--) begin
            if (rd_sel[SEL_VID+i])
                mux_d = vid_dout[i];
        end
        if (rd_sel[SEL_IN])
            mux_d = port_in;
        if (rd_sel[SEL_PAL])
            mux_d = pal_dout;
        if (rd_sel[SEL_ROM])
            mux_d = rom_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            cpu_din <= IDLE_DATA;
        else
            cpu_din <= mux_d;
    end

endmodule

// ==== logic/main_bus.sv ====
// Main CPU bus glue, top level
// Reads: cpu_din valid two edges after the address, held while it stays
// Writes: take effect on the cpu_cen edge
// ROM reads stall through bus_wait until rom_ok; palette RAM is external
`timescale 1ns/1ps

module main_bus import map_pkg::*, cab_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_cen,
    input  logic [15:0]                 addr,
    input  logic                        rnw,
    input  logic [7:0]                  cpu_dout,
    output logic [7:0]                  cpu_din,
    output logic                        bus_wait,
    output logic [ROM_AW-1:0]           rom_addr,
    output logic                        rom_cs,
    input  logic [7:0]                  rom_data,
    input  logic                        rom_ok,
    input  logic [BTN_W-1:0]            start_button,
    input  logic [BTN_W-1:0]            coin_input,
    input  logic [JOY_W-1:0]            joystick1,
    input  logic [JOY_W-1:0]            joystick2,
    input  logic                        service,
    input  logic [DSW_W-1:0]            dipsw_a,
    input  logic [DSW_W-1:0]            dipsw_b,
    input  logic [DSWC_W-1:0]           dipsw_c,
    input  logic                        dip_pause,
    input  logic                        gfx_irqn,
    input  logic                        irq_ack,
    output logic                        irq_n,
    output logic                        snd_irq,
    output logic [7:0]                  snd_latch,
    output logic                        pal_cs,
    input  logic [7:0]                  pal_dout,
    output logic [NUM_VID*CFG_N*8-1:0]  vid_cfg
);

    logic [NUM_VID-1:0] vram_cs;
    logic [NUM_VID-1:0] cfg_cs;
    logic               in_cs;
    logic               out_cs;
    logic [SEL_N-1:0]   rd_sel;
    logic [7:0]         port_in;
    logic [7:0]         vid_dout [NUM_VID];

    main_decode u_decode (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .addr(addr), .rnw(rnw),
        .cpu_dout(cpu_dout), .rom_ok(rom_ok), .rom_cs(rom_cs), .rom_addr(rom_addr),
        .bus_wait(bus_wait), .vram_cs(vram_cs), .cfg_cs(cfg_cs), .pal_cs(pal_cs),
        .in_cs(in_cs), .out_cs(out_cs), .rd_sel(rd_sel)
    );

    // Both chips share the CPU window, video_sel picks one through the selects
    for (genvar g = 0; g < NUM_VID; g++) begin : g_vid
        vid_port u_vid (
            .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .rnw(rnw),
            .addr(addr[VRAM_AW-1:0]), .cpu_dout(cpu_dout),
            .vram_cs(vram_cs[g]), .cfg_cs(cfg_cs[g]), .vid_dout(vid_dout[g]),
            .cfg_regs(vid_cfg[g*CFG_N*8 +: CFG_N*8])
        );
    end

    cab_inputs u_cab (
        .clk(clk), .in_cs(in_cs), .addr_lo(addr[2:0]), .start_button(start_button),
        .coin_input(coin_input), .joystick1(joystick1), .joystick2(joystick2),
        .service(service), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .port_in(port_in)
    );

    snd_comm u_snd (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .out_cs(out_cs), .addr(addr[2:1]),
        .cpu_dout(cpu_dout), .gfx_irqn(gfx_irqn), .dip_pause(dip_pause),
        .irq_ack(irq_ack), .snd_irq(snd_irq), .snd_latch(snd_latch), .irq_n(irq_n)
    );

    bus_mux u_mux (
        .clk(clk), .rst(rst), .rd_sel(rd_sel), .rom_data(rom_data),
        .pal_dout(pal_dout), .port_in(port_in), .vid_dout(vid_dout), .cpu_din(cpu_din)
    );

endmodule

// ==== verif/main_bus_sva.sv ====
// Protocol assertions for the main bus glue, bound to main_bus
// All checks are off while rst is high
// The irq_n check assumes gfx_irqn is held high through reset
`timescale 1ns/1ps

module main_bus_sva import map_pkg::*, cab_pkg::*; (
    input logic               clk,
    input logic               rst,
    input logic               cpu_cen,
    input logic               rnw,
    input logic [15:0]        addr,
    input logic               snd_irq,
    input logic               out_cs,
    input logic               rom_cs,
    input logic               pal_cs,
    input logic               in_cs,
    input logic [NUM_VID-1:0] vram_cs,
    input logic [NUM_VID-1:0] cfg_cs,
    input logic               bus_wait,
    input logic               irq_n,
    input logic               gfx_irqn,
    input logic               dip_pause
);

    logic irq_wr;   // A new sound interrupt write on this cycle

    assign irq_wr = cpu_cen && out_cs && !rnw && addr[2:1] == OUT_SND_IRQ;

    // Pulse ends at the next bus cycle unless it is retriggered
    a_snd_irq_len: assert property (@(posedge clk) disable iff (rst)
        snd_irq && cpu_cen && !irq_wr |=> !snd_irq)
        else $error("snd_irq held past one cpu_cen period");

    a_sel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, pal_cs, in_cs, out_cs, vram_cs, cfg_cs}))
        else $error("more than one chip select active");

    a_wait_rom: assert property (@(posedge clk) disable iff (rst)
        bus_wait |-> rom_cs)
        else $error("bus_wait without rom_cs");

    // irq_n may only fall after a sampled gfx_irqn fall while running
    a_irq_src: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> !$past(gfx_irqn, 1) && $past(gfx_irqn, 2) && $past(dip_pause, 1))
        else $error("irq_n fell without a gfx_irqn fall");

endmodule

// ==== verif/main_bus_tb.sv ====
// Testbench for the main bus glue; the tb acts as the CPU
// ROM model answers after a random number of cycles through rom_ok
// Reads sample cpu_din at the falling edge, two rising edges after the address
// All bus waits give up after WAIT_MAX cycles
`timescale 1ns/1ps

module main_bus_tb import map_pkg::*, cab_pkg::*;;

    localparam int WAIT_MAX = 100;
    localparam logic [15:0] IDLE_ADDR = 16'h0C00;   // Decodes to nothing

    logic clk = 1'b0;
    logic rst;
    logic cpu_cen, rnw;
    logic [15:0] addr;
    logic [7:0] cpu_dout, cpu_din;
    logic bus_wait, rom_cs, rom_ok;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0] rom_data, pal_dout, snd_latch;
    logic [BTN_W-1:0] start_button, coin_input;
    logic [JOY_W-1:0] joystick1, joystick2;
    logic service, dip_pause, gfx_irqn, irq_ack, irq_n, snd_irq, pal_cs;
    logic [DSW_W-1:0] dipsw_a, dipsw_b;
    logic [DSWC_W-1:0] dipsw_c;
    logic [NUM_VID*CFG_N*8-1:0] vid_cfg;

    integer seed = 18050;
    integer errors = 0;
    integer test_err0 = 0;
    integer tests_ok = 0;
    integer tests_bad = 0;
    integer rom_delay = 0;
    integer wait_cnt = 0;
    integer wait_seen;              // Cycles with bus_wait high in the last read
    logic [ROM_AW-1:0] seen_rom_addr;
    logic seen_rom_cs;              // Selects seen once the read address settles
    logic seen_pal_cs;

    always #10 clk = ~clk;

    main_bus u_dut (.*);

    bind main_bus main_bus_sva u_sva (
        .clk(clk), .rst(rst), .cpu_cen(cpu_cen), .rnw(rnw), .addr(addr),
        .snd_irq(snd_irq), .out_cs(out_cs), .rom_cs(rom_cs), .pal_cs(pal_cs),
        .in_cs(in_cs), .vram_cs(vram_cs), .cfg_cs(cfg_cs), .bus_wait(bus_wait),
        .irq_n(irq_n), .gfx_irqn(gfx_irqn), .dip_pause(dip_pause)
    );

    // ROM content depends on every address bit
    function automatic logic [7:0] rom_model(input logic [ROM_AW-1:0] a);
        return 8'(a[7:0] ^ a[15:8] ^ {7'd0, a[16]} ^ 8'h5A) + 8'(a[12:5]);
    endfunction

    // ROM answers rom_delay cycles after rom_cs rises
    always @(posedge clk) begin
        rom_data <= rom_model(rom_addr);
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            wait_cnt <= 0;
        end else if (wait_cnt >= rom_delay) begin
            rom_ok <= 1'b1;
        end else begin
            wait_cnt <= wait_cnt + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (exp === got)
        else begin
            $display("Fail t=%0t %s expected=%h actual=%h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic abort(input string why);
        $display("Timeout at t=%0t: %s", $time, why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (errors == test_err0) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge clk);
        addr     <= a;
        rnw      <= 1'b0;
        cpu_dout <= d;
        cpu_cen  <= 1'b1;
        @(posedge clk);   // Write lands on this edge
        cpu_cen  <= 1'b0;
        rnw      <= 1'b1;
        addr     <= IDLE_ADDR;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        integer n;
        @(posedge clk);
        addr <= a;
        rnw  <= 1'b1;
        @(negedge clk);
        seen_rom_addr = rom_addr;
        seen_rom_cs = rom_cs;
        seen_pal_cs = pal_cs;
        wait_seen = 0;
        for (n = 0; n < WAIT_MAX && bus_wait; n++) begin
            wait_seen++;
            @(negedge clk);
        end
        if (bus_wait)
            abort("bus_wait never fell");
        @(posedge clk);
        @(posedge clk);
        @(negedge clk);
        d = cpu_din;
        @(posedge clk);
        addr <= IDLE_ADDR;
    endtask

    function automatic logic [7:0] joy_layout(input logic [JOY_W-1:0] j);
        return {2'b11, j[5], j[4], j[2], j[3], j[0], j[1]};
    endfunction

    initial begin
        logic [7:0] d;
        logic [7:0] vdat [NUM_VID][8];
        logic [12:0] vadr [8];
        logic [7:0] cfg_exp [NUM_VID][CFG_N];
        logic [3:0] b;
        logic [15:0] a;
        logic [ROM_AW-1:0] ea;
        integer i, v, n;

        rst = 1'b1;
        cpu_cen = 1'b0;
        rnw = 1'b1;
        addr = IDLE_ADDR;
        cpu_dout = 8'h00;
        rom_ok = 1'b0;
        rom_data = 8'h00;
        pal_dout = 8'h00;
        start_button = '1;
        coin_input = '1;
        joystick1 = '1;
        joystick2 = '1;
        service = 1'b1;
        dipsw_a = '1;
        dipsw_b = '1;
        dipsw_c = '1;
        dip_pause = 1'b1;
        gfx_irqn = 1'b1;
        irq_ack = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // 1: reset state
        check("snd_irq", 0, 32'(snd_irq));
        check("snd_latch", 0, 32'(snd_latch));
        check("irq_n", 1, 32'(irq_n));
        assert (vid_cfg == '0)
        else begin
            $display("Fail t=%0t vid_cfg expected=0 actual=%h", $time, vid_cfg);
            errors++;
        end
        end_test("reset");

        // 2: banking and ROM wait
        for (i = 0; i < 6; i++) begin
            b = 4'($random(seed));
            rom_delay = $random(seed) & 7;
            bus_write(16'h4000, {4'd0, b});
            a = 16'h4000 | 16'($random(seed) & 16'h3FFF);
            bus_read(a, d);
            ea = {4'(b + 4'd4), a[12:0]};
            check("rom_cs", 1, 32'(seen_rom_cs));
            check("rom_addr", 32'(ea), 32'(seen_rom_addr));
            check("cpu_din", 32'(rom_model(ea)), 32'(d));
            check("bus_wait_cycles", rom_delay + 1, wait_seen);
            a = 16'h8000 | 16'($random(seed) & 16'h7FFF);
            bus_read(a, d);
            ea = {2'b00, a[14:0]};
            check("rom_addr", 32'(ea), 32'(seen_rom_addr));
            check("cpu_din", 32'(rom_model(ea)), 32'(d));
        end
        rom_delay = 0;
        end_test("banking");

        // 3: video ports, chip 0 then chip 1 on the same addresses
        for (i = 0; i < 8; i++)
            vadr[i] = 13'(i * 997 + ($random(seed) & 63));
        for (v = 0; v < NUM_VID; v++) begin
            bus_write(16'h4000, 8'(v << 4));   // Bank 0, video_sel v
            for (i = 0; i < 8; i++) begin
                vdat[v][i] = 8'($random(seed));
                bus_write(16'h2000 | 16'(vadr[i]), vdat[v][i]);
            end
            for (i = 0; i < CFG_N; i++) begin
                cfg_exp[v][i] = 8'($random(seed));
                bus_write(16'(i), cfg_exp[v][i]);
            end
        end
        for (v = 0; v < NUM_VID; v++) begin
            bus_write(16'h4000, 8'(v << 4));
            for (i = 0; i < 8; i++) begin
                bus_read(16'h2000 | 16'(vadr[i]), d);
                check("vram_rd", 32'(vdat[v][i]), 32'(d));
            end
            for (i = 0; i < CFG_N; i++)
                check("vid_cfg", 32'(cfg_exp[v][i]), 32'(vid_cfg[(v*CFG_N+i)*8 +: 8]));
        end
        end_test("video ports");

        // 4: cabinet inputs
        for (n = 0; n < 4; n++) begin
            @(posedge clk);
            start_button <= 2'($random(seed));
            coin_input   <= 2'($random(seed));
            service      <= 1'($random(seed));
            joystick1    <= 6'($random(seed));
            joystick2    <= 6'($random(seed));
            dipsw_a      <= 8'($random(seed));
            dipsw_b      <= 8'($random(seed));
            dipsw_c      <= 4'($random(seed));
            bus_read(16'h0400, d);
            check("port_sys", 32'({3'b111, start_button, service, coin_input}), 32'(d));
            bus_read(16'h0401, d);
            check("port_joy1", 32'(joy_layout(joystick1)), 32'(d));
            bus_read(16'h0402, d);
            check("port_joy2", 32'(joy_layout(joystick2)), 32'(d));
            bus_read(16'h0404, d);
            check("port_dswa", 32'(dipsw_a), 32'(d));
            bus_read(16'h0405, d);
            check("port_dswb", 32'(dipsw_b), 32'(d));
            bus_read(16'h0406, d);
            check("port_dswc", 32'({4'hF, dipsw_c}), 32'(d));
        end
        bus_read(16'h0403, d);
        check("unmapped_0403", 32'hFF, 32'(d));
        bus_read(16'h0407, d);
        check("unmapped_0407", 32'hFF, 32'(d));
        bus_read(IDLE_ADDR, d);
        check("unmapped_0c00", 32'hFF, 32'(d));
        end_test("cabinet");

        // Palette reads pass the external RAM data through
        for (n = 0; n < 4; n++) begin
            @(posedge clk);
            pal_dout <= 8'($random(seed));
            a = 16'h0600 | 16'($random(seed) & 8'hFF);
            bus_read(a, d);
            check("pal_cs", 1, 32'(seen_pal_cs));
            check("pal_rd", 32'(pal_dout), 32'(d));
        end
        end_test("palette");

        // 5: sound latch and interrupt pulse
        d = 8'($random(seed));
        bus_write(16'h0414, d);
        @(negedge clk);
        check("snd_latch", 32'(d), 32'(snd_latch));
        check("snd_irq", 0, 32'(snd_irq));
        bus_write(16'h0412, 8'h00);
        @(negedge clk);
        check("snd_irq", 1, 32'(snd_irq));
        repeat (3) @(negedge clk);
        check("snd_irq", 1, 32'(snd_irq));      // Held until the next cpu_cen
        bus_write(IDLE_ADDR, 8'h00);
        @(negedge clk);
        check("snd_irq", 0, 32'(snd_irq));
        end_test("sound");

        // 6: video interrupt with acknowledge
        @(posedge clk);
        gfx_irqn <= 1'b0;
        for (n = 0; n < WAIT_MAX && irq_n; n++)
            @(negedge clk);
        if (irq_n)
            abort("irq_n never fell after gfx_irqn fall");
        @(posedge clk);
        gfx_irqn <= 1'b1;
        repeat (3) @(negedge clk);
        check("irq_n_latched", 0, 32'(irq_n));   // Stays low until acknowledged
        @(posedge clk);
        irq_ack  <= 1'b1;
        @(posedge clk);
        irq_ack  <= 1'b0;
        for (n = 0; n < WAIT_MAX && !irq_n; n++)
            @(negedge clk);
        if (!irq_n)
            abort("irq_n not cleared by irq_ack");
        @(posedge clk);
        dip_pause <= 1'b0;   // Paused, falls are ignored
        @(posedge clk);
        gfx_irqn  <= 1'b0;
        repeat (4) @(negedge clk);
        check("irq_n_paused", 1, 32'(irq_n));
        @(posedge clk);
        gfx_irqn  <= 1'b1;
        dip_pause <= 1'b1;
        end_test("video irq");

        repeat (2) @(posedge clk);
        $display("Tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/map_pkg.sv
logic/cab_pkg.sv
logic/main_decode.sv
logic/vid_port.sv
logic/cab_inputs.sv
logic/snd_comm.sv
logic/bus_mux.sv
logic/main_bus.sv
verif/main_bus_sva.sv
verif/main_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the main bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    -f sources.f \
    --top-module main_bus_tb \
    -o sim_main_bus

# The simulation status is judged from the log below
./obj_dir/sim_main_bus > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation completed successfully$" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
